/* source/attn_proj_cfg.svh */
// Fixed 16-bit addresses and 32-bit words; NUM_PROJECTIONS must be at least 2 and 3*N*P+1 must fit in an address
`ifndef ATTN_PROJ_CFG_SVH
`define ATTN_PROJ_CFG_SVH

// SRAM port widths
`define SRAM_ADDR_WIDTH 16
`define SRAM_DATA_WIDTH 32

// One header field is half a word
`define DIM_WIDTH 16

// Q, K and V
`define NUM_PROJECTIONS 3

// Header sits at word 0 and data starts right after it
`define HEADER_ADDR 0
`define DATA_BASE_ADDR 1

`endif

/* source/sram_pkg.sv */
// Word-wide SRAM port types; read ports carry only an address and return data one cycle later
`default_nettype none

`include "attn_proj_cfg.svh"

package sram_pkg;

  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;

  // One write port, enable in the top bit
  typedef struct packed {
    logic       we;
    sram_addr_t addr;
    sram_data_t data;
  } sram_write_t;

endpackage

`default_nettype wire

/* source/proj_pkg.sv */
// Job control types for the projection engine; dimensions are unsigned and never zero
`default_nettype none

`include "attn_proj_cfg.svh"

package proj_pkg;

  typedef logic [`DIM_WIDTH-1:0] dim_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_DIMS,
    LOAD_DIMS,
    STREAM,
    DRAIN
  } proj_state_e;

  // M x N input, N x P weights
  typedef struct packed {
    dim_t rows;
    dim_t inner;
    dim_t cols;
  } matrix_dims_t;

  // Travels with each read pair through the datapath
  typedef struct packed {
    logic valid;
    logic last_k;
    logic last_all;
  } elem_tag_t;

endpackage

`default_nettype wire

/* source/proj_controller.sv */
// Job sequencer; dut_valid is ignored unless dut_ready is high and there is no abort once a job starts
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module proj_controller (
  input  wire  clk,
  input  wire  reset_n,
  input  wire  dut_valid,
  input  wire  stream_done,
  input  wire  job_done,
  output logic dut_ready,
  output logic read_dims,
  output logic load_dims,
  output logic stream_enable
);

  import proj_pkg::*;

  proj_state_e state;
  proj_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      dut_ready <= 1'b0;
    end else begin
      state     <= state_nxt;
      // Ready follows the state one edge later so it stays low just after reset
      dut_ready <= (state_nxt == IDLE);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (dut_valid && dut_ready) begin
          state_nxt = READ_DIMS;
        end
      end
      READ_DIMS: begin
        state_nxt = LOAD_DIMS;
      end
      LOAD_DIMS: begin
        state_nxt = STREAM;
      end
      STREAM: begin
        if (stream_done) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        // Wait for the last sum to leave the write port
        if (job_done) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  assign read_dims     = (state == READ_DIMS);
  assign load_dims     = (state == LOAD_DIMS);
  assign stream_enable = (state == STREAM);

endmodule

`default_nettype wire

/* source/read_addr_gen.sv */
// Read address walker; weight rows are assumed equal to N and the upper half of the weight header is ignored
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module read_addr_gen (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire                        read_dims,
  input  wire                        load_dims,
  input  wire                        stream_enable,
  input  wire  sram_pkg::sram_data_t input_read_data,
  input  wire  sram_pkg::sram_data_t weight_read_data,
  output sram_pkg::sram_addr_t       input_read_address,
  output sram_pkg::sram_addr_t       weight_read_address,
  output proj_pkg::elem_tag_t        tag,
  output logic                       stream_done
);

  import sram_pkg::*;
  import proj_pkg::*;

  localparam int                PROJ_W    = $clog2(`NUM_PROJECTIONS);
  localparam logic [PROJ_W-1:0] LAST_PROJ = PROJ_W'(`NUM_PROJECTIONS - 1);
  localparam logic [PROJ_W-1:0] PROJ_ONE  = PROJ_W'(1);
  localparam sram_addr_t        HDR_ADDR  = sram_addr_t'(`HEADER_ADDR);
  localparam sram_addr_t        BASE_ADDR = sram_addr_t'(`DATA_BASE_ADDR);
  localparam sram_addr_t        ADDR_ONE  = sram_addr_t'(1);
  localparam dim_t              DIM_ONE   = dim_t'(1);

  matrix_dims_t      dims;
  matrix_dims_t      hdr_dims;

  // Position of the pair now on the ports
  logic [PROJ_W-1:0] proj_idx;
  dim_t              row_idx;
  dim_t              col_idx;
  dim_t              k_idx;
  // Start of the current input row and of the current weight matrix
  sram_addr_t        row_base;
  sram_addr_t        mat_base;

  logic [PROJ_W-1:0] proj_nxt;
  dim_t              row_nxt;
  dim_t              col_nxt;
  dim_t              k_nxt;
  sram_addr_t        row_base_nxt;
  sram_addr_t        mat_base_nxt;
  sram_addr_t        in_addr_nxt;
  sram_addr_t        w_addr_nxt;
  logic              end_k;
  logic              end_col;
  logic              end_row;
  elem_tag_t         tag_nxt;

  assign hdr_dims = '{rows:  input_read_data[`SRAM_DATA_WIDTH-1 -: `DIM_WIDTH],
                      inner: input_read_data[`DIM_WIDTH-1:0],
                      cols:  weight_read_data[`DIM_WIDTH-1:0]};

  // Step to the next product; addresses move by one except where a loop wraps
  always_comb begin
    end_k        = (k_idx == dims.inner - DIM_ONE);
    end_col      = end_k && (col_idx == dims.cols - DIM_ONE);
    end_row      = end_col && (row_idx == dims.rows - DIM_ONE);
    k_nxt        = end_k ? '0 : k_idx + DIM_ONE;
    col_nxt      = end_k ? (end_col ? '0 : col_idx + DIM_ONE) : col_idx;
    row_nxt      = end_col ? (end_row ? '0 : row_idx + DIM_ONE) : row_idx;
    proj_nxt     = end_row ? proj_idx + PROJ_ONE : proj_idx;
    in_addr_nxt  = input_read_address + ADDR_ONE;
    w_addr_nxt   = weight_read_address + ADDR_ONE;
    row_base_nxt = row_base;
    mat_base_nxt = mat_base;
    if (end_row) begin
      in_addr_nxt  = BASE_ADDR;
      row_base_nxt = BASE_ADDR;
      mat_base_nxt = w_addr_nxt;
    end else if (end_col) begin
      row_base_nxt = in_addr_nxt;
      w_addr_nxt   = mat_base;
    end else if (end_k) begin
      // Same input row again for the next weight column
      in_addr_nxt  = row_base;
    end
  end

  // Tag of the next pair; the first pair of a job sees the header as it arrives
  always_comb begin
    tag_nxt.valid    = 1'b1;
    tag_nxt.last_k   = load_dims ? (hdr_dims.inner == DIM_ONE) :
                                   (k_nxt == dims.inner - DIM_ONE);
    // No job ends on its first pair since there are several projections
    tag_nxt.last_all = !load_dims && tag_nxt.last_k &&
                       (col_nxt == dims.cols - DIM_ONE) &&
                       (row_nxt == dims.rows - DIM_ONE) && (proj_nxt == LAST_PROJ);
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      input_read_address  <= HDR_ADDR;
      weight_read_address <= HDR_ADDR;
      tag                 <= '0;
      proj_idx            <= '0;
      row_idx             <= '0;
      col_idx             <= '0;
      k_idx               <= '0;
      row_base            <= BASE_ADDR;
      mat_base            <= BASE_ADDR;
    end else if (read_dims) begin
      input_read_address  <= HDR_ADDR;
      weight_read_address <= HDR_ADDR;
      tag                 <= '0;
    end else if (load_dims) begin
      input_read_address  <= BASE_ADDR;
      weight_read_address <= BASE_ADDR;
      tag                 <= tag_nxt;
      proj_idx            <= '0;
      row_idx             <= '0;
      col_idx             <= '0;
      k_idx               <= '0;
      row_base            <= BASE_ADDR;
      mat_base            <= BASE_ADDR;
    end else if (stream_enable && tag.valid) begin
      if (tag.last_all) begin
        input_read_address  <= HDR_ADDR;
        weight_read_address <= HDR_ADDR;
        tag                 <= '0;
      end else begin
        input_read_address  <= in_addr_nxt;
        weight_read_address <= w_addr_nxt;
        tag                 <= tag_nxt;
        proj_idx            <= proj_nxt;
        row_idx             <= row_nxt;
        col_idx             <= col_nxt;
        k_idx               <= k_nxt;
        row_base            <= row_base_nxt;
        mat_base            <= mat_base_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_dims) begin
      dims <= hdr_dims;
    end
  end

  assign stream_done = tag.last_all;

endmodule

`default_nettype wire

/* source/mac_unit.sv */
// Integer multiply-accumulate; products and sums wrap modulo 2^32 and read data must lag its address by one cycle
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module mac_unit (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire  proj_pkg::elem_tag_t  tag,
  input  wire  sram_pkg::sram_data_t input_read_data,
  input  wire  sram_pkg::sram_data_t weight_read_data,
  output sram_pkg::sram_data_t       sum,
  output proj_pkg::elem_tag_t        sum_tag
);

  import sram_pkg::*;
  import proj_pkg::*;

  elem_tag_t  tag_q;
  sram_data_t acc;

  // Sum including the product now on the read data
  assign sum = acc + input_read_data * weight_read_data;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag_q <= '0;
      acc   <= '0;
    end else begin
      // Tag lines up with the data returning from the SRAMs
      tag_q <= tag;
      if (tag_q.valid) begin
        // Next element starts from zero
        acc <= tag_q.last_k ? '0 : sum;
      end
    end
  end

  assign sum_tag = tag_q;

endmodule

`default_nettype wire

/* source/result_writer.sv */
// Result write port; addresses restart at zero for every job and writes are never held off
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module result_writer (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire  sram_pkg::sram_data_t sum,
  input  wire  proj_pkg::elem_tag_t  sum_tag,
  output sram_pkg::sram_write_t      result_write,
  output logic                       job_done
);

  import sram_pkg::*;

  localparam sram_addr_t ADDR_ONE = sram_addr_t'(1);

  logic       finished;
  logic       wr_en_q;
  sram_addr_t wr_ptr;
  sram_addr_t wr_addr_q;
  sram_data_t wr_data_q;

  assign finished = sum_tag.valid && sum_tag.last_k;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_en_q  <= 1'b0;
      job_done <= 1'b0;
      wr_ptr   <= '0;
    end else begin
      wr_en_q  <= finished;
      job_done <= finished && sum_tag.last_all;
      if (finished) begin
        wr_ptr <= sum_tag.last_all ? '0 : wr_ptr + ADDR_ONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (finished) begin
      wr_addr_q <= wr_ptr;
      wr_data_q <= sum;
    end
  end

  assign result_write = '{we: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

/* source/attn_proj_top.sv */
// Q, K and V projection engine; one job at a time and SRAM reads must return after exactly one cycle
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module attn_proj_top (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire                        dut_valid,
  output logic                       dut_ready,
  output sram_pkg::sram_addr_t       input_read_address,
  input  wire  sram_pkg::sram_data_t input_read_data,
  output sram_pkg::sram_addr_t       weight_read_address,
  input  wire  sram_pkg::sram_data_t weight_read_data,
  output sram_pkg::sram_write_t      result_write
);

  import sram_pkg::*;
  import proj_pkg::*;

  logic       read_dims;
  logic       load_dims;
  logic       stream_enable;
  logic       stream_done;
  logic       job_done;
  elem_tag_t  tag;
  elem_tag_t  sum_tag;
  sram_data_t sum;

  proj_controller u_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .stream_done   (stream_done),
    .job_done      (job_done),
    .dut_ready     (dut_ready),
    .read_dims     (read_dims),
    .load_dims     (load_dims),
    .stream_enable (stream_enable)
  );

  read_addr_gen u_addr (
    .clk                 (clk),
    .reset_n             (reset_n),
    .read_dims           (read_dims),
    .load_dims           (load_dims),
    .stream_enable       (stream_enable),
    .input_read_data     (input_read_data),
    .weight_read_data    (weight_read_data),
    .input_read_address  (input_read_address),
    .weight_read_address (weight_read_address),
    .tag                 (tag),
    .stream_done         (stream_done)
  );

  mac_unit u_mac (
    .clk              (clk),
    .reset_n          (reset_n),
    .tag              (tag),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .sum              (sum),
    .sum_tag          (sum_tag)
  );

  result_writer u_wr (
    .clk          (clk),
    .reset_n      (reset_n),
    .sum          (sum),
    .sum_tag      (sum_tag),
    .result_write (result_write),
    .job_done     (job_done)
  );

endmodule

`default_nettype wire

/* dv/attn_proj_properties.sv */
// Port checks for the projection engine; only active outside reset and expect write addresses from zero per job
`timescale 1ns/1ps
`default_nettype none

module attn_proj_properties (
  input wire                        clk,
  input wire                        reset_n,
  input wire                        dut_valid,
  input wire                        dut_ready,
  input wire sram_pkg::sram_write_t result_write
);

  import sram_pkg::*;

  sram_addr_t next_addr;

  // Address the next write of the current job should use
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      next_addr <= '0;
    end else if (result_write.we) begin
      next_addr <= result_write.addr + sram_addr_t'(1);
    end else if (dut_ready) begin
      next_addr <= '0;
    end
  end

  no_write_while_ready: assert property (@(posedge clk) disable iff (!reset_n)
    !(result_write.we && dut_ready))
    else $error("result write while dut_ready is high");

  ready_falls_on_start: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |=> !dut_ready)
    else $error("dut_ready stayed high after an accepted dut_valid");

  write_addr_steps: assert property (@(posedge clk) disable iff (!reset_n)
    result_write.we |-> (result_write.addr == next_addr))
    else $error("result write address did not step by one");

endmodule

bind attn_proj_top attn_proj_properties u_props (
  .clk          (clk),
  .reset_n      (reset_n),
  .dut_valid    (dut_valid),
  .dut_ready    (dut_ready),
  .result_write (result_write)
);

`default_nettype wire

/* dv/tb_attn_proj.sv */
// SRAM models are 1024 words deep and answer one cycle after the address; jobs must fit in them
`timescale 1ns/1ps
`default_nettype none

`include "attn_proj_cfg.svh"

module tb_attn_proj;

  import sram_pkg::*;
  import proj_pkg::*;

  localparam int MEM_DEPTH = 1024;
  localparam int NUM_JOBS  = 5;
  localparam int TIMEOUT   = 2000;

  typedef struct packed {
    matrix_dims_t dims;
    logic [15:0]  writes;
  } job_entry_t;

  logic        clk;
  logic        reset_n;
  logic        dut_valid;
  logic        dut_ready;
  sram_addr_t  input_read_address;
  sram_data_t  input_read_data = '0;
  sram_addr_t  weight_read_address;
  sram_data_t  weight_read_data = '0;
  sram_write_t result_write;

  sram_data_t  in_mem  [MEM_DEPTH];
  sram_data_t  w_mem   [MEM_DEPTH];
  sram_data_t  res_mem [MEM_DEPTH];
  job_entry_t  jobs    [NUM_JOBS];
  int          wr_total = 0;
  int          job_base = 0;

  attn_proj_top uut (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .input_read_address  (input_read_address),
    .input_read_data     (input_read_data),
    .weight_read_address (weight_read_address),
    .weight_read_data    (weight_read_data),
    .result_write        (result_write)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h exp %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic wait_ready(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (dut_ready !== 1'b1 && cycles < limit);
    assert (dut_ready === 1'b1) else begin
      $display("Timed out after %0d cycles waiting for dut_ready to rise", limit);
      stop_on_error();
    end
  endtask

  task automatic wait_write(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (result_write.we !== 1'b1 && cycles < limit);
    assert (result_write.we === 1'b1) else begin
      $display("Timed out after %0d cycles waiting for a result write", limit);
      stop_on_error();
    end
  endtask

  function automatic logic [9:0] mem_index(input int a);
    return 10'(a);
  endfunction

  function automatic job_entry_t make_job(input int m, input int n, input int p, input int w);
    job_entry_t e;
    e.dims.rows  = 16'(m);
    e.dims.inner = 16'(n);
    e.dims.cols  = 16'(p);
    e.writes     = 16'(w);
    return e;
  endfunction

  // Sum over k of input[i][k] * weight_m[k][j], weights stored column by column
  function automatic sram_data_t expected_word(input matrix_dims_t d, input int m, input int i,
                                               input int j);
    sram_data_t acc;
    int         n;
    int         p;
    int         in_base;
    int         w_base;
    int         k;
    n       = int'(d.inner);
    p       = int'(d.cols);
    acc     = '0;
    in_base = `DATA_BASE_ADDR + i * n;
    w_base  = `DATA_BASE_ADDR + m * n * p + j * n;
    for (k = 0; k < n; k++) begin
      acc = acc + in_mem[mem_index(in_base + k)] * w_mem[mem_index(w_base + k)];
    end
    return acc;
  endfunction

  task automatic load_memories(input matrix_dims_t d);
    int a;
    for (a = 0; a < MEM_DEPTH; a++) begin
      in_mem[mem_index(a)] = $urandom();
      w_mem[mem_index(a)]  = $urandom();
    end
    in_mem[`HEADER_ADDR] = {d.rows, d.inner};
    w_mem[`HEADER_ADDR]  = {d.inner, d.cols};
  endtask

  task automatic check_results(input matrix_dims_t d);
    int m;
    int i;
    int j;
    int addr;
    for (m = 0; m < `NUM_PROJECTIONS; m++) begin
      for (i = 0; i < int'(d.rows); i++) begin
        for (j = 0; j < int'(d.cols); j++) begin
          addr = m * int'(d.rows) * int'(d.cols) + i * int'(d.cols) + j;
          check_word($sformatf("result_write.data at addr %h", addr),
                     res_mem[mem_index(addr)], expected_word(d, m, i, j));
        end
      end
    end
  endtask

  always @(posedge clk) begin
    input_read_data  <= in_mem[input_read_address[9:0]];
    weight_read_data <= w_mem[weight_read_address[9:0]];
  end

  // Result SRAM; writes of a job must come in address order from zero
  always @(posedge clk) begin
    if (reset_n && result_write.we) begin
      assert (result_write.addr == sram_addr_t'(wr_total - job_base)) else begin
        $display("ERR result_write.addr got %h exp %h", result_write.addr,
                 sram_addr_t'(wr_total - job_base));
        stop_on_error();
      end
      res_mem[result_write.addr[9:0]] = result_write.data;
      wr_total = wr_total + 1;
    end
  end

  initial begin
    int t;
    int gap;
    void'($urandom(32'h13c72319));
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    // M, N, P and the number of result words
    jobs[0] = make_job(1, 1, 1, 3);
    jobs[1] = make_job(2, 3, 2, 12);
    jobs[2] = make_job(4, 4, 4, 48);
    jobs[3] = make_job(3, 1, 5, 45);
    jobs[4] = make_job(2, 5, 3, 18);
    repeat (16) @(posedge clk);
    reset_n   <= 1'b1;
    // Strobe in the first cycle after reset, before dut_ready rises
    dut_valid <= 1'b1;
    @(negedge clk);
    check_word("dut_ready", 32'(dut_ready), 32'd0);
    check_word("result_write.we", 32'(result_write.we), 32'd0);
    @(posedge clk);
    dut_valid <= 1'b0;
    for (t = 0; t < NUM_JOBS; t++) begin
      wait_ready(TIMEOUT);
      load_memories(jobs[t].dims);
      job_base = wr_total;
      // Ready holds while idle
      gap = $urandom_range(3, 0);
      repeat (gap) begin
        @(negedge clk);
        check_word("dut_ready", 32'(dut_ready), 32'd1);
      end
      @(posedge clk);
      dut_valid <= 1'b1;
      @(posedge clk);
      dut_valid <= 1'b0;
      @(negedge clk);
      check_word("dut_ready", 32'(dut_ready), 32'd0);
      // Stray strobe while busy must be ignored
      wait_write(TIMEOUT);
      @(posedge clk);
      dut_valid <= 1'b1;
      @(posedge clk);
      dut_valid <= 1'b0;
      wait_ready(TIMEOUT);
      check_word("write count", 32'(wr_total - job_base), 32'(jobs[t].writes));
      check_results(jobs[t].dims);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/sram_pkg.sv
source/proj_pkg.sv
source/proj_controller.sv
source/read_addr_gen.sv
source/mac_unit.sv
source/result_writer.sv
source/attn_proj_top.sv
dv/attn_proj_properties.sv
dv/tb_attn_proj.sv

/* Makefile */
TB_TOP  = tb_attn_proj
RTL_TOP = attn_proj_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TB_TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
